// ==== vlog.f ====
rtl/core_pkg.sv
rtl/register_file.sv
rtl/operand_forward.sv
rtl/int_alu.sv
rtl/mem_align_check.sv
rtl/dual_issue_backend.sv
verification/tb_backend.sv

// ==== verification/tb_backend.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_backend;
    import core_pkg::*;

    localparam int clk_period    = 20;
    localparam int drain_groups  = 5;
    localparam int random_groups = 400;
    // idle, alu, dependency, same rd, mem and random groups with their drains
    localparam int test_groups   = 10 + 76 + 38 + 8 + 28 + random_groups +
                                   5 * drain_groups + 2;
    localparam int timeout_cycles = 4 + test_groups + 200;

    logic      clk;
    logic      rstn;
    issue_op_t issue0;
    issue_op_t issue1;
    wb_t       wb0;
    wb_t       wb1;
    mem_req_t  mem_req;
    excp_t     excp;

    logic [31:0] model_regs [32];
    logic [31:0] rng_state;
    int          checks;
    int          errors;

    // expected outputs in the order they appear
    wb_t      exp_wb0  [$];
    wb_t      exp_wb1  [$];
    mem_req_t exp_req  [$];
    excp_t    exp_excp [$];

    dual_issue_backend dut (
        .clk     (clk),
        .rstn    (rstn),
        .issue0  (issue0),
        .issue1  (issue1),
        .wb0     (wb0),
        .wb1     (wb1),
        .mem_req (mem_req),
        .excp    (excp)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic issue_op_t alu_op(input logic [4:0] sub, input logic s1,
                                         input logic [1:0] s2, input logic [4:0] rj,
                                         input logic [4:0] rk, input logic [4:0] rd,
                                         input logic [31:0] imm, input logic [31:0] pc);
        issue_op_t op;
        op = '0;
        op.valid = 1'b1;
        op.pc = pc;
        op.ctl.alu.cls = cls_alu;
        op.ctl.alu.subtype = sub;
        op.ctl.alu.src1 = s1;
        op.ctl.alu.src2 = s2;
        op.rj = rj;
        op.rk = rk;
        op.rd = rd;
        op.imm = imm;
        return op;
    endfunction

    function automatic issue_op_t mem_op(input logic [4:0] sub, input logic [4:0] rj,
                                         input logic [4:0] rd, input logic [31:0] imm,
                                         input logic [31:0] pc);
        issue_op_t op;
        op = '0;
        op.valid = 1'b1;
        op.pc = pc;
        op.ctl.mem.cls = cls_mem;
        op.ctl.mem.subtype = sub;
        op.rj = rj;
        op.rd = rd;
        op.imm = imm;
        return op;
    endfunction

    // model of one integer op on the current model state
    function automatic logic [31:0] expect_alu(input issue_op_t op);
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  s;
        a = (op.ctl.alu.src1 == src1_pc) ? op.pc : model_regs[op.rj];
        if (op.ctl.alu.src2 == src2_imm) begin
            b = op.imm;
        end else if (op.ctl.alu.src2 == src2_four) begin
            b = 32'd4;
        end else begin
            b = model_regs[op.rk];
        end
        s = b[4:0];
        case (op.ctl.alu.subtype)
            alu_add:  return a + b;
            alu_sub:  return a + ~b + 32'd1;
            alu_slt:  return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_nor:  return ~(a | b);
            alu_sll:  return a << s;
            alu_srl:  return a >> s;
            alu_sra:  return (a >> s) | (a[31] ? ~(32'hffff_ffff >> s) : 32'd0);
            alu_lui:  return b;
            default:  return 32'd0;
        endcase
    endfunction

    function automatic wb_t expect_wb(input issue_op_t op);
        wb_t w;
        w = '0;
        w.en = op.valid && op.ctl.alu.cls == cls_alu && op.rd != 5'd0;
        w.addr = op.rd;
        if (w.en) begin
            w.data = expect_alu(op);
        end
        return w;
    endfunction

    task automatic expect_mem(input issue_op_t op, output mem_req_t r, output excp_t x);
        logic [31:0] addr;
        logic        bad;
        r = '0;
        x = '0;
        if (op.valid && op.ctl.mem.cls == cls_mem) begin
            addr = model_regs[op.rj] + op.imm;
            r.addr = addr;
            r.store = op.ctl.mem.subtype inside {mem_st_b, mem_st_h, mem_st_w};
            if (op.ctl.mem.subtype inside {mem_ld_b, mem_st_b}) begin
                r.size = size_byte;
            end else if (op.ctl.mem.subtype inside {mem_ld_h, mem_st_h}) begin
                r.size = size_half;
            end else begin
                r.size = size_word;
            end
            bad = (r.size == size_half && addr[0]) || (r.size == size_word && addr[1:0] != 0);
            r.wdata = model_regs[op.rd];
            r.valid = !bad;
            x.valid = bad;
            x.pc = op.pc;
            x.code = excp_ale;
        end
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %0d ns %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_wb(input string name, input wb_t got, input wb_t exp);
        check_field({name, ".en"}, got.en, exp.en);
        if (exp.en) begin
            check_field({name, ".addr"}, got.addr, exp.addr);
            check_field({name, ".data"}, got.data, exp.data);
        end
    endtask

    task automatic compare_outputs();
        wb_t      w0;
        wb_t      w1;
        mem_req_t r;
        excp_t    x;
        w0 = exp_wb0.pop_front();
        w1 = exp_wb1.pop_front();
        r = exp_req.pop_front();
        x = exp_excp.pop_front();
        check_wb("wb0", wb0, w0);
        check_wb("wb1", wb1, w1);
        check_field("mem_req.valid", mem_req.valid, r.valid);
        if (r.valid) begin
            check_field("mem_req.addr", mem_req.addr, r.addr);
            check_field("mem_req.size", mem_req.size, r.size);
            check_field("mem_req.store", mem_req.store, r.store);
            if (r.store) begin
                check_field("mem_req.wdata", mem_req.wdata, r.wdata);
            end
        end
        check_field("excp.valid", excp.valid, x.valid);
        if (x.valid) begin
            check_field("excp.pc", excp.pc, x.pc);
            check_field("excp.code", excp.code, x.code);
        end
    endtask

    // one issue group, model update, then compare the outputs due this cycle
    task automatic step(input issue_op_t op0, input issue_op_t op1);
        wb_t      w0;
        wb_t      w1;
        mem_req_t r;
        excp_t    x;
        @(posedge clk);
        issue0 <= op0;
        issue1 <= op1;
        w0 = expect_wb(op0);
        w1 = expect_wb(op1);
        expect_mem(op1, r, x);
        if (w0.en) begin
            model_regs[w0.addr] = w0.data;
        end
        // lane 1 lands last
        if (w1.en) begin
            model_regs[w1.addr] = w1.data;
        end
        exp_wb0.push_back(w0);
        exp_wb1.push_back(w1);
        exp_req.push_back(r);
        exp_excp.push_back(x);
        @(negedge clk);
        compare_outputs();
    endtask

    task automatic idle_groups(input int n);
        repeat (n) step('0, '0);
    endtask

    task automatic alu_test();
        logic [31:0] seeds [8];
        logic [1:0]  s2;
        int          idx;
        seeds = '{32'h8000_0013, 32'h0000_0007, 32'hffff_fff0, 32'h1234_5678,
                  32'h7fff_ffff, 32'h0000_001f, 32'h8765_4321, 32'h0000_0004};
        for (int i = 0; i < 4; i++) begin
            step(alu_op(alu_lui, src1_reg, src2_imm, 0, 0, 5'(1 + i), seeds[i], 0),
                 alu_op(alu_lui, src1_reg, src2_imm, 0, 0, 5'(5 + i), seeds[4 + i], 0));
        end
        idx = 0;
        for (int sub = 0; sub < 12; sub++) begin
            for (int s1 = 0; s1 < 2; s1++) begin
                for (int k = 0; k < 3; k++) begin
                    s2 = (k == 0) ? src2_reg : (k == 1) ? src2_imm : src2_four;
                    step(alu_op(5'(sub), s1[0], s2, 5'(1 + sub % 4), 5'(1 + (sub + k + 1) % 4),
                                20, 32'hffff_ff00 + 7 * sub + k, 32'h1c00_0000 + 8 * idx),
                         alu_op(5'(sub), s1[0], s2, 5'(5 + (sub + s1) % 4), 5'(5 + (sub + 2) % 4),
                                21, 32'h13 * (sub + 1), 32'h1c00_0004 + 8 * idx));
                    idx++;
                end
            end
        end
        idle_groups(drain_groups);
    endtask

    task automatic mem_test();
        step(alu_op(alu_lui, src1_reg, src2_imm, 0, 0, 9, 32'h0000_1000, 0),
             alu_op(alu_lui, src1_reg, src2_imm, 0, 0, 10, 32'hcafe_f00d, 0));
        for (int sub = 0; sub < 6; sub++) begin
            for (int off = 0; off < 4; off++) begin
                step('0, mem_op(5'(sub), 9, 10, off, 32'h1c00_1000 + 16 * sub + 4 * off));
            end
        end
        // base comes from the previous group through forwarding
        step(alu_op(alu_lui, src1_reg, src2_imm, 0, 0, 12, 32'h0000_2002, 0), '0);
        step('0, mem_op(mem_st_w, 12, 10, 2, 32'h1c00_2000));
        step('0, mem_op(mem_ld_h, 12, 0, 1, 32'h1c00_2004));
        idle_groups(drain_groups);
    endtask

    task automatic dependency_test();
        int        gaps [4];
        issue_op_t older;
        issue_op_t newer;
        issue_op_t rd1_op;
        gaps = '{1, 2, 3, 5};
        for (int lane = 0; lane < 2; lane++) begin
            for (int g = 0; g < 4; g++) begin
                older = alu_op(alu_lui, src1_reg, src2_imm, 0, 0, 22, 32'h1111_0000 + g, 0);
                newer = alu_op(alu_lui, src1_reg, src2_imm, 0, 0, 22,
                               32'hbeef_0000 + 16 * lane + g, 0);
                step(older, '0);
                if (lane == 0) begin
                    step(newer, '0);
                end else begin
                    step('0, newer);
                end
                idle_groups(gaps[g] - 1);
                // odd chains read r22 as store data instead
                if (g % 2 == 0) begin
                    rd1_op = alu_op(alu_or, src1_reg, src2_reg, 0, 22, 24, 0, 0);
                end else begin
                    rd1_op = mem_op(mem_st_w, 0, 22, 32'h100, 32'h1c00_3000 + 4 * g);
                end
                step(alu_op(alu_add, src1_reg, src2_reg, 22, 0, 23, 0, 0), rd1_op);
            end
        end
        idle_groups(drain_groups);
    endtask

    task automatic same_rd_test();
        step(alu_op(alu_lui, src1_reg, src2_imm, 0, 0, 13, 32'haaaa_0001, 0),
             alu_op(alu_lui, src1_reg, src2_imm, 0, 0, 13, 32'hbbbb_0002, 0));
        step(alu_op(alu_add, src1_reg, src2_reg, 13, 0, 14, 0, 0), '0);
        idle_groups(3);
        step('0, alu_op(alu_add, src1_reg, src2_reg, 13, 0, 15, 0, 0));
        step(alu_op(alu_lui, src1_reg, src2_imm, 0, 0, 0, 32'hdead_0000, 0),
             alu_op(alu_lui, src1_reg, src2_imm, 0, 0, 0, 32'hbeef_0000, 0));
        step(alu_op(alu_add, src1_reg, src2_imm, 0, 0, 16, 32'h55, 0),
             alu_op(alu_or, src1_reg, src2_reg, 0, 0, 17, 0, 0));
        idle_groups(drain_groups + 2);
    endtask

    // lane 0 writes only r0..r15 and lane 1 reads only r0 and r16..r31
    task automatic random_test();
        issue_op_t   op0;
        issue_op_t   op1;
        logic [31:0] r;
        for (int g = 0; g < random_groups; g++) begin
            r = xorshift();
            op0 = alu_op(5'(r % 12), r[4], (r[6:5] == 2'd2) ? src2_four : r[6:5], r[11:7],
                         r[16:12], {1'b0, r[20:17]}, xorshift(), xorshift() & 32'hffff_fffc);
            op0.valid = r[23:21] != 3'd0;
            r = xorshift();
            if (r[1:0] == 2'd0) begin
                op1 = mem_op(5'(r[10:2] % 6), r[11] ? {1'b1, r[15:12]} : 5'd0,
                             {1'b1, r[19:16]}, {{24{r[27]}}, r[27:20]},
                             xorshift() & 32'hffff_fffc);
            end else begin
                op1 = alu_op(5'(r % 12), r[4], (r[6:5] == 2'd2) ? src2_imm : r[6:5],
                             r[7] ? {1'b1, r[11:8]} : 5'd0, {1'b1, r[15:12]}, r[20:16],
                             xorshift(), xorshift() & 32'hffff_fffc);
            end
            op1.valid = r[30:28] != 3'd0;
            step(op0, op1);
        end
        idle_groups(drain_groups);
    endtask

    initial begin
        #(timeout_cycles * clk_period);
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        issue0 = '0;
        issue1 = '0;
        rng_state = 32'h5bb76800;
        checks = 0;
        errors = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        // outputs before the first op reaches them
        repeat (4) exp_wb0.push_back('0);
        repeat (4) exp_wb1.push_back('0);
        repeat (3) exp_req.push_back('0);
        repeat (3) exp_excp.push_back('0);
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        idle_groups(10);
        alu_test();
        dependency_test();
        same_rd_test();
        mem_test();
        random_test();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/dual_issue_backend.sv ====
`timescale 1ns/10ps
`default_nettype none

module dual_issue_backend (
    input  logic                 clk,
    input  logic                 rstn,
    input  core_pkg::issue_op_t  issue0,
    input  core_pkg::issue_op_t  issue1,
    output core_pkg::wb_t        wb0,
    output core_pkg::wb_t        wb1,
    output core_pkg::mem_req_t   mem_req,
    output core_pkg::excp_t      excp
);
    import core_pkg::*;

    // stage registers indexed by lane
    issue_op_t       id_op   [2];
    issue_op_t       ex_op   [2];
    logic [xlen-1:0] ex_rrj  [2];
    logic [xlen-1:0] ex_rrk  [2];
    logic [xlen-1:0] ex_rrd  [2];
    wb_t             ee_wb   [2];
    mem_req_t        ee_req;
    excp_t           ee_excp;
    wb_t             wb_q    [2];

    // combinational values between the registers
    logic [xlen-1:0] rf_rj   [2];
    logic [xlen-1:0] rf_rk   [2];
    logic [xlen-1:0] rf_rd   [2];
    logic [xlen-1:0] fwd_rj  [2];
    logic [xlen-1:0] fwd_rk  [2];
    logic [xlen-1:0] fwd_rd  [2];
    logic [xlen-1:0] alu_res [2];
    ctl_u            ex_ctl  [2];
    wb_t             ex_wb   [2];
    ctl_u            chk_ctl;
    mem_req_t        chk_req;
    logic [5:0]      chk_code;
    mem_req_t        ex_req;
    excp_t           ex_excp;

    // id/reg
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            id_op[0] <= '0;
            id_op[1] <= '0;
        end else begin
            id_op[0] <= issue0;
            id_op[1] <= issue1;
        end
    end

    register_file u_register_file (
        .clk  (clk),
        .rstn (rstn),
        .wr0  (wb_q[0]),
        .wr1  (wb_q[1]),
        .rj0  (id_op[0].rj),
        .rk0  (id_op[0].rk),
        .rd0  (id_op[0].rd),
        .rj1  (id_op[1].rj),
        .rk1  (id_op[1].rk),
        .rd1  (id_op[1].rd),
        .rrj0 (rf_rj[0]),
        .rrk0 (rf_rk[0]),
        .rrd0 (rf_rd[0]),
        .rrj1 (rf_rj[1]),
        .rrk1 (rf_rk[1]),
        .rrd1 (rf_rd[1])
    );

    // reg/exe0
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ex_op[0] <= '0;
            ex_op[1] <= '0;
        end else begin
            ex_op[0] <= id_op[0];
            ex_op[1] <= id_op[1];
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < 2; l++) begin
            ex_rrj[l] <= rf_rj[l];
            ex_rrk[l] <= rf_rk[l];
            ex_rrd[l] <= rf_rd[l];
        end
    end

    // only lane 1 can carry a memory op
    mem_align_check u_mem_align_check (
        .op_ctl    (ex_op[1].ctl),
        .rj_val    (fwd_rj[1]),
        .imm       (ex_op[1].imm),
        .rd_val    (fwd_rd[1]),
        .out_ctl   (chk_ctl),
        .req       (chk_req),
        .excp_code (chk_code)
    );

    assign ex_ctl[0] = ex_op[0].ctl;
    assign ex_ctl[1] = chk_ctl;

    for (genvar l = 0; l < 2; l++) begin : g_lane
        operand_forward u_operand_forward (
            .src_rj (ex_op[l].rj),
            .src_rk (ex_op[l].rk),
            .src_rd (ex_op[l].rd),
            .reg_rj (ex_rrj[l]),
            .reg_rk (ex_rrk[l]),
            .reg_rd (ex_rrd[l]),
            .exe1_0 (ee_wb[0]),
            .exe1_1 (ee_wb[1]),
            .wb_0   (wb_q[0]),
            .wb_1   (wb_q[1]),
            .fwd_rj (fwd_rj[l]),
            .fwd_rk (fwd_rk[l]),
            .fwd_rd (fwd_rd[l])
        );

        int_alu u_int_alu (
            .ctl    (ex_op[l].ctl.alu),
            .rj_val (fwd_rj[l]),
            .rk_val (fwd_rk[l]),
            .pc     (ex_op[l].pc),
            .imm    (ex_op[l].imm),
            .result (alu_res[l])
        );

        // loads, stores and exceptions write nothing back
        always_comb begin
            ex_wb[l].en   = ex_op[l].valid && ex_ctl[l].alu.cls == cls_alu &&
                            ex_op[l].rd != '0;
            ex_wb[l].addr = ex_op[l].rd;
            ex_wb[l].data = (ex_ctl[l].alu.cls == cls_alu) ? alu_res[l] : '0;
        end
    end

    always_comb begin
        ex_req        = chk_req;
        ex_req.valid  = chk_req.valid && ex_op[1].valid;
        ex_excp.valid = ex_op[1].valid && chk_ctl.mem.cls == cls_excp;
        ex_excp.pc    = ex_op[1].pc;
        ex_excp.code  = chk_code;
    end

    // exe0/exe1 is also the forwarding source for the next group
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ee_wb[0] <= '0;
            ee_wb[1] <= '0;
            ee_req   <= '0;
            ee_excp  <= '0;
        end else begin
            ee_wb[0] <= ex_wb[0];
            ee_wb[1] <= ex_wb[1];
            ee_req   <= ex_req;
            ee_excp  <= ex_excp;
        end
    end

    // exe1/wb
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wb_q[0] <= '0;
            wb_q[1] <= '0;
        end else begin
            wb_q[0] <= ee_wb[0];
            wb_q[1] <= ee_wb[1];
        end
    end

    assign wb0     = wb_q[0];
    assign wb1     = wb_q[1];
    assign mem_req = ee_req;
    assign excp    = ee_excp;

endmodule

`default_nettype wire

// ==== rtl/mem_align_check.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_align_check (
    input  core_pkg::ctl_u            op_ctl,
    input  logic [core_pkg::xlen-1:0] rj_val,
    input  logic [core_pkg::xlen-1:0] imm,
    input  logic [core_pkg::xlen-1:0] rd_val,
    output core_pkg::ctl_u            out_ctl,
    output core_pkg::mem_req_t        req,
    output logic [5:0]                excp_code
);
    import core_pkg::*;

    logic [xlen-1:0] addr;
    size_t           size;
    logic            store;
    logic            misaligned;

    assign addr = rj_val + imm;

    // size and direction straight from the subtype
    always_comb begin
        case (op_ctl.mem.subtype)
            mem_ld_b, mem_st_b: size = size_byte;
            mem_ld_h, mem_st_h: size = size_half;
            default:            size = size_word;
        endcase
        store = op_ctl.mem.subtype inside {mem_st_b, mem_st_h, mem_st_w};
        misaligned = (size == size_half && addr[0]) ||
                     (size == size_word && addr[1:0] != 2'b00);
    end

    // a bad access leaves exe0 as an exception op
    always_comb begin
        out_ctl   = op_ctl;
        req       = '0;
        excp_code = '0;
        if (op_ctl.mem.cls == cls_mem) begin
            if (misaligned) begin
                out_ctl.mem.cls = cls_excp;
                excp_code       = excp_ale;
            end else begin
                req.valid = 1'b1;
                req.addr  = addr;
                req.size  = size;
                req.store = store;
                req.wdata = store ? rd_val : '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/int_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module int_alu (
    input  core_pkg::alu_ctl_t        ctl,
    input  logic [core_pkg::xlen-1:0] rj_val,
    input  logic [core_pkg::xlen-1:0] rk_val,
    input  logic [core_pkg::xlen-1:0] pc,
    input  logic [core_pkg::xlen-1:0] imm,
    output logic [core_pkg::xlen-1:0] result
);
    import core_pkg::*;

    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [4:0]      shamt;
    logic            lt_s;
    logic            lt_u;

    // operand muxes
    always_comb begin
        if (ctl.src1 == src1_pc) begin
            src1 = pc;
        end else begin
            src1 = rj_val;
        end
        case (ctl.src2)
            src2_imm:  src2 = imm;
            src2_four: src2 = xlen'(4);
            default:   src2 = rk_val;
        endcase
    end

    assign shamt = src2[4:0];
    assign lt_s  = $signed(src1) < $signed(src2);
    assign lt_u  = src1 < src2;

    always_comb begin
        case (ctl.subtype)
            alu_add: begin
                result = src1 + src2;
            end
            alu_sub: begin
                result = src1 - src2;
            end
            alu_slt: begin
                result = {{(xlen-1){1'b0}}, lt_s};
            end
            alu_sltu: begin
                result = {{(xlen-1){1'b0}}, lt_u};
            end
            alu_and: begin
                result = src1 & src2;
            end
            alu_or: begin
                result = src1 | src2;
            end
            alu_xor: begin
                result = src1 ^ src2;
            end
            alu_nor: begin
                result = ~(src1 | src2);
            end
            alu_sll: begin
                result = src1 << shamt;
            end
            alu_srl: begin
                result = src1 >> shamt;
            end
            alu_sra: begin
                result = $signed(src1) >>> shamt;
            end
            alu_lui: begin
                result = src2;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/operand_forward.sv ====
`timescale 1ns/10ps
`default_nettype none

module operand_forward (
    input  logic [core_pkg::reg_addr_w-1:0] src_rj,
    input  logic [core_pkg::reg_addr_w-1:0] src_rk,
    input  logic [core_pkg::reg_addr_w-1:0] src_rd,
    input  logic [core_pkg::xlen-1:0]       reg_rj,
    input  logic [core_pkg::xlen-1:0]       reg_rk,
    input  logic [core_pkg::xlen-1:0]       reg_rd,
    input  core_pkg::wb_t                   exe1_0,
    input  core_pkg::wb_t                   exe1_1,
    input  core_pkg::wb_t                   wb_0,
    input  core_pkg::wb_t                   wb_1,
    output logic [core_pkg::xlen-1:0]       fwd_rj,
    output logic [core_pkg::xlen-1:0]       fwd_rk,
    output logic [core_pkg::xlen-1:0]       fwd_rd
);
    import core_pkg::*;

    // newest producer first and lane 1 before lane 0 within a stage
    function automatic logic [xlen-1:0] newest(
        input logic [reg_addr_w-1:0] src,
        input logic [xlen-1:0]       reg_val
    );
        logic [xlen-1:0] val;
        val = reg_val;
        if (src != '0) begin
            if (exe1_1.en && exe1_1.addr == src) begin
                val = exe1_1.data;
            end else if (exe1_0.en && exe1_0.addr == src) begin
                val = exe1_0.data;
            end else if (wb_1.en && wb_1.addr == src) begin
                val = wb_1.data;
            end else if (wb_0.en && wb_0.addr == src) begin
                val = wb_0.data;
            end
        end
        return val;
    endfunction

    // older results already came through the register file bypass
    always_comb begin
        fwd_rj = newest(src_rj, reg_rj);
        fwd_rk = newest(src_rk, reg_rk);
        fwd_rd = newest(src_rd, reg_rd);
    end

endmodule

`default_nettype wire

// ==== rtl/register_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module register_file (
    input  logic                            clk,
    input  logic                            rstn,
    input  core_pkg::wb_t                   wr0,
    input  core_pkg::wb_t                   wr1,
    input  logic [core_pkg::reg_addr_w-1:0] rj0,
    input  logic [core_pkg::reg_addr_w-1:0] rk0,
    input  logic [core_pkg::reg_addr_w-1:0] rd0,
    input  logic [core_pkg::reg_addr_w-1:0] rj1,
    input  logic [core_pkg::reg_addr_w-1:0] rk1,
    input  logic [core_pkg::reg_addr_w-1:0] rd1,
    output logic [core_pkg::xlen-1:0]       rrj0,
    output logic [core_pkg::xlen-1:0]       rrk0,
    output logic [core_pkg::xlen-1:0]       rrd0,
    output logic [core_pkg::xlen-1:0]       rrj1,
    output logic [core_pkg::xlen-1:0]       rrk1,
    output logic [core_pkg::xlen-1:0]       rrd1
);
    import core_pkg::*;

    logic [xlen-1:0]       regs  [num_regs];
    logic [reg_addr_w-1:0] raddr [6];
    logic [xlen-1:0]       rdata [6];

    // r0 is never written, so it keeps its reset value
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr0.en && wr0.addr != '0) begin
                regs[wr0.addr] <= wr0.data;
            end
            // lane 1 is younger and lands last
            if (wr1.en && wr1.addr != '0) begin
                regs[wr1.addr] <= wr1.data;
            end
        end
    end

    assign raddr = '{rj0, rk0, rd0, rj1, rk1, rd1};

    // write-through so a read sees this cycle's writeback
    always_comb begin
        for (int p = 0; p < 6; p++) begin
            if (raddr[p] == '0) begin
                rdata[p] = '0;
            end else if (wr1.en && wr1.addr == raddr[p]) begin
                rdata[p] = wr1.data;
            end else if (wr0.en && wr0.addr == raddr[p]) begin
                rdata[p] = wr0.data;
            end else begin
                rdata[p] = regs[raddr[p]];
            end
        end
    end

    assign rrj0 = rdata[0];
    assign rrk0 = rdata[1];
    assign rrd0 = rdata[2];
    assign rrj1 = rdata[3];
    assign rrk1 = rdata[4];
    assign rrd1 = rdata[5];

endmodule

`default_nettype wire

// ==== rtl/core_pkg.sv ====
`default_nettype none

package core_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;

    // op classes in the decoder control word numbering
    localparam logic [3:0] cls_alu  = 4'd0;
    localparam logic [3:0] cls_excp = 4'd3;
    localparam logic [3:0] cls_mem  = 4'd5;

    // alu subtypes
    localparam logic [4:0] alu_add  = 5'd0;
    localparam logic [4:0] alu_sub  = 5'd1;
    localparam logic [4:0] alu_slt  = 5'd2;
    localparam logic [4:0] alu_sltu = 5'd3;
    localparam logic [4:0] alu_and  = 5'd4;
    localparam logic [4:0] alu_or   = 5'd5;
    localparam logic [4:0] alu_xor  = 5'd6;
    localparam logic [4:0] alu_nor  = 5'd7;
    localparam logic [4:0] alu_sll  = 5'd8;
    localparam logic [4:0] alu_srl  = 5'd9;
    localparam logic [4:0] alu_sra  = 5'd10;
    // lui just passes source 2
    localparam logic [4:0] alu_lui  = 5'd11;

    // memory subtypes with loads below stores
    localparam logic [4:0] mem_ld_b = 5'd0;
    localparam logic [4:0] mem_ld_h = 5'd1;
    localparam logic [4:0] mem_ld_w = 5'd2;
    localparam logic [4:0] mem_st_b = 5'd3;
    localparam logic [4:0] mem_st_h = 5'd4;
    localparam logic [4:0] mem_st_w = 5'd5;

    // operand source selects
    localparam logic       src1_reg  = 1'b0;
    localparam logic       src1_pc   = 1'b1;
    localparam logic [1:0] src2_reg  = 2'd0;
    localparam logic [1:0] src2_imm  = 2'd1;
    localparam logic [1:0] src2_four = 2'd3;

    // address not aligned
    localparam logic [5:0] excp_ale = 6'b001001;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } size_t;

    typedef struct packed {
        logic       src1;
        logic [1:0] src2;
        logic [4:0] subtype;
        logic [3:0] pad;
        logic [3:0] cls;
    } alu_ctl_t;

    typedef struct packed {
        logic [6:0] pad;
        logic [4:0] subtype;
        logic [3:0] cls;
    } mem_ctl_t;

    // class sits in [3:0] in both views and picks the view
    typedef union packed {
        alu_ctl_t alu;
        mem_ctl_t mem;
    } ctl_u;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        ctl_u                  ctl;
        logic [reg_addr_w-1:0] rj;
        logic [reg_addr_w-1:0] rk;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       imm;
    } issue_op_t;

    typedef struct packed {
        logic                  en;
        logic [reg_addr_w-1:0] addr;
        logic [xlen-1:0]       data;
    } wb_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] addr;
        size_t           size;
        logic            store;
        logic [xlen-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [5:0]      code;
    } excp_t;

endpackage

`default_nettype wire
